/* Makefile */
# Verilator build and run of the waveform buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_wvb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

/* tb_wvb.sv */
/*
 * Testbench for the two-channel waveform buffer. Fires events on both
 * channels and checks every popped header and sample readback against
 * values computed here. Run through the Makefile or any simulator with verilog.f.
 */
`timescale 1ns/1ns
`include "wvb_cfg.svh"

module tb_wvb;
  import wvb_trig_pkg::*;
  import wvb_hdr_pkg::*;

  // minimum lengths enforced by the write controller
  localparam int PRE_MIN = 3;
  localparam int POST_MIN = 2;
  localparam int TEST_MIN = 3;
  localparam int CONST_MIN = 3;

  localparam int N_TESTS = 6;
  localparam int CYC_PER_TEST = 200;
  localparam int MARGIN_CYC = 1000;
  localparam int WD_CYCLES = N_TESTS * CYC_PER_TEST + MARGIN_CYC;

  logic                   clk = 1'b0;
  logic                   i_rst;
  logic [`WVB_LTC_W-1:0]  i_ltc;
  len_cfg_t               i_len_cfg;
  logic                   i_trig_mode;
  logic                   i_cnst_run;
  logic [`WVB_N_CH-1:0]   i_arm;
  logic [`WVB_N_CH-1:0]   i_trig;
  trig_src_t              i_trig_src [`WVB_N_CH];
  logic                   i_sync_rdy;
  logic [`WVB_DATA_W-1:0] i_sample [`WVB_N_CH];
  ch_idx_t                i_rd_ch;
  logic [`WVB_ADR_W-1:0]  i_rd_addr;
  logic                   i_hdr_rd;
  logic [`WVB_N_CH-1:0]   o_armed;
  logic [`WVB_N_CH-1:0]   o_overflow;
  logic                   o_hdr_valid;
  hdr_entry_t             o_hdr;
  logic [`WVB_DATA_W-1:0] o_rd_data;

  // headers still to come out of the FIFO, any channel order
  hdr_entry_t            exp_q [$];
  logic [`WVB_ADR_W-1:0] exp_addr [`WVB_N_CH];
  logic                  pop_en;
  int                    errors;
  int                    checks;
  int                    n_tests;
  int                    n_failed;
  int                    err_at_start;
  string                 test_name;

  wvb_top i_dut (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_ltc       (i_ltc),
    .i_len_cfg   (i_len_cfg),
    .i_trig_mode (i_trig_mode),
    .i_cnst_run  (i_cnst_run),
    .i_arm       (i_arm),
    .i_trig      (i_trig),
    .i_trig_src  (i_trig_src),
    .i_sync_rdy  (i_sync_rdy),
    .i_sample    (i_sample),
    .i_rd_ch     (i_rd_ch),
    .i_rd_addr   (i_rd_addr),
    .i_hdr_rd    (i_hdr_rd),
    .o_armed     (o_armed),
    .o_overflow  (o_overflow),
    .o_hdr_valid (o_hdr_valid),
    .o_hdr       (o_hdr),
    .o_rd_data   (o_rd_data)
  );

  always #10 clk = ~clk;

  function automatic int clamp(input int val, input int min_val);
    return (val < min_val) ? min_val : val;
  endfunction

  // number of samples one event writes
  function automatic int exp_len(input trig_src_t src, input logic cnst, input len_cfg_t cfg);
    if (src == TRIG_SRC_SW || src == TRIG_SRC_EXT) begin
      return clamp(int'(cfg.test_len), TEST_MIN);
    end else if (cnst) begin
      return clamp(int'(cfg.const_len), CONST_MIN);
    end
    return 2 + clamp(int'(cfg.pre_len), PRE_MIN) + clamp(int'(cfg.post_len), POST_MIN);
  endfunction

  // sample word tagged with channel and full ring address
  function automatic logic [`WVB_DATA_W-1:0] pat(input logic ch, input logic [7:0] addr);
    return {ch, 3'b101, addr};
  endfunction

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_at_start = errors;
    n_tests++;
  endtask

  task automatic finish_test();
    if (errors == err_at_start) begin
      $display("test %0d %s: ok", n_tests, test_name);
    end else begin
      $display("test %0d %s: FAILED with %0d errors", n_tests, test_name, errors - err_at_start);
      n_failed++;
    end
  endtask

  task automatic do_reset();
    i_rst = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    i_rst = 1'b0;
    exp_addr[0] = '0;
    exp_addr[1] = '0;
    exp_q.delete();
  endtask

  // config must sit for two idle cycles before the next trigger
  task automatic set_cfg(input int pre, input int post, input int tst, input int cst);
    i_len_cfg.pre_len = 5'(pre);
    i_len_cfg.post_len = 8'(post);
    i_len_cfg.test_len = 8'(tst);
    i_len_cfg.const_len = 8'(cst);
    repeat (3) @(negedge clk);
  endtask

  // one-cycle trigger on the masked channels, samples follow the write address
  task automatic fire(input logic [1:0] mask, input trig_src_t src, input logic live,
                      output int len);
    hdr_entry_t e;
    len = exp_len(src, i_cnst_run, i_len_cfg);
    i_ltc = $urandom;
    i_sync_rdy = 1'($urandom_range(0, 1));
    i_trig_src[0] = src;
    i_trig_src[1] = src;
    i_trig = mask;
    for (int c = 0; c < 2; c++) begin
      if (live && mask[c]) begin
        e.ch = ch_idx_t'(c);
        e.hdr.evt_ltc = i_ltc;
        e.hdr.start_addr = exp_addr[c];
        e.hdr.stop_addr = exp_addr[c] + 8'(len - 1);
        e.hdr.trig_src = src;
        e.hdr.cnst_run = i_cnst_run;
        e.hdr.pre_conf = 5'(clamp(int'(i_len_cfg.pre_len), PRE_MIN));
        e.hdr.sync_rdy = i_sync_rdy;
        exp_q.push_back(e);
      end
    end
    for (int k = 0; k < len; k++) begin
      i_sample[0] = pat(1'b0, exp_addr[0] + 8'(k));
      i_sample[1] = pat(1'b1, exp_addr[1] + 8'(k));
      @(negedge clk);
      i_trig = '0;
      // local time keeps counting while the event runs
      i_ltc = i_ltc + 1'b1;
    end
    for (int c = 0; c < 2; c++) begin
      if (live && mask[c]) begin
        exp_addr[c] = exp_addr[c] + 8'(len);
      end
    end
    repeat (4) @(negedge clk);
  endtask

  // extra cycles at the end let a stray header show up
  task automatic drain();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk);
  endtask

  // address on one falling edge, data checked on the next
  task automatic read_back(input logic ch, input logic [7:0] start, input int len);
    i_rd_ch = ch;
    for (int i = 0; i <= len; i++) begin
      if (i > 0) begin
        checks++;
        assert (o_rd_data === pat(ch, start + 8'(i - 1))) else begin
          $display("MISMATCH %0t: ch%0d sample at %0d is %h, expected %h", $time, ch,
                   start + 8'(i - 1), o_rd_data, pat(ch, start + 8'(i - 1)));
          errors++;
        end
      end
      if (i < len) begin
        i_rd_addr = start + 8'(i);
      end
      @(negedge clk);
    end
  endtask

  // pops every header and matches it with the oldest one expected for its channel
  initial begin : compare_hdrs
    hdr_entry_t got;
    int idx;
    int j;
    i_hdr_rd = 1'b0;
    forever begin
      @(negedge clk);
      i_hdr_rd = 1'b0;
      if (pop_en && o_hdr_valid && !i_rst) begin
        got = o_hdr;
        idx = -1;
        for (j = 0; j < exp_q.size(); j++) begin
          if (idx < 0 && exp_q[j].ch == got.ch) begin
            idx = j;
          end
        end
        checks++;
        assert (idx >= 0) else begin
          $display("ERROR %0t: header from channel %0d arrived but none was expected",
                   $time, got.ch);
          errors++;
        end
        if (idx >= 0) begin
          checks++;
          assert (got.hdr == exp_q[idx].hdr) else begin
            $display("MISMATCH %0t: ch%0d header %h, expected %h, start %0d/%0d, stop %0d/%0d",
                     $time, got.ch, got.hdr, exp_q[idx].hdr, got.hdr.start_addr,
                     exp_q[idx].hdr.start_addr, got.hdr.stop_addr,
                     exp_q[idx].hdr.stop_addr);
            errors++;
          end
          exp_q.delete(idx);
        end
        i_hdr_rd = 1'b1;
      end
    end
  end

  initial begin : watchdog
    repeat (WD_CYCLES) @(posedge clk);
    $display("TIMEOUT: run did not finish within %0d cycles", WD_CYCLES);
    $display("Regression failed");
    $finish;
  end

  initial begin : stimulus
    int len;
    logic [7:0] s;
    void'($urandom(70));
    i_rst = 1'b1;
    i_ltc = '0;
    i_len_cfg = '0;
    i_trig_mode = 1'b0;
    i_cnst_run = 1'b0;
    i_arm = '0;
    i_trig = '0;
    i_trig_src[0] = TRIG_SRC_THRESH;
    i_trig_src[1] = TRIG_SRC_THRESH;
    i_sync_rdy = 1'b0;
    i_sample[0] = '0;
    i_sample[1] = '0;
    i_rd_ch = '0;
    i_rd_addr = '0;
    pop_en = 1'b1;
    errors = 0;
    checks = 0;
    n_tests = 0;
    n_failed = 0;
    do_reset();

    start_test("software and external trigger length");
    for (int n = 0; n < 4; n++) begin
      // channel 0 gets lengths below the minimum, channel 1 above it
      if (n[0]) begin
        set_cfg(4, 3, $urandom_range(TEST_MIN, 20), 5);
      end else begin
        set_cfg(4, 3, $urandom_range(0, TEST_MIN - 1), 5);
      end
      fire(n[0] ? 2'b10 : 2'b01, n[1] ? TRIG_SRC_EXT : TRIG_SRC_SW, 1'b1, len);
    end
    drain();
    finish_test();

    start_test("threshold window and readback");
    for (int n = 0; n < 2; n++) begin
      if (n == 0) begin
        set_cfg($urandom_range(0, PRE_MIN - 1), $urandom_range(0, POST_MIN - 1), 5, 5);
      end else begin
        set_cfg($urandom_range(PRE_MIN, 12), $urandom_range(POST_MIN, 12), 5, 5);
      end
      s = exp_addr[n];
      fire(n[0] ? 2'b10 : 2'b01, TRIG_SRC_THRESH, 1'b1, len);
      drain();
      read_back(n[0], s, len);
    end
    finish_test();

    start_test("constant run length");
    i_cnst_run = 1'b1;
    for (int n = 0; n < 2; n++) begin
      if (n == 0) begin
        set_cfg(4, 3, 5, $urandom_range(0, CONST_MIN - 1));
      end else begin
        set_cfg(4, 3, 5, $urandom_range(CONST_MIN, 20));
      end
      fire(n[0] ? 2'b10 : 2'b01, TRIG_SRC_THRESH, 1'b1, len);
    end
    drain();
    i_cnst_run = 1'b0;
    finish_test();

    start_test("armed trigger mode");
    i_trig_mode = 1'b1;
    set_cfg(4, 3, 6, 5);
    fire(2'b01, TRIG_SRC_SW, 1'b0, len);
    drain();
    check_bit(o_armed[0], 1'b0, "o_armed[0] before arm");
    i_arm = 2'b01;
    @(negedge clk);
    i_arm = '0;
    check_bit(o_armed[0], 1'b1, "o_armed[0] after arm");
    fire(2'b01, TRIG_SRC_SW, 1'b1, len);
    check_bit(o_armed[0], 1'b0, "o_armed[0] after header");
    drain();
    i_trig_mode = 1'b0;
    finish_test();

    start_test("both channels at once");
    set_cfg(4, 3, 6, 5);
    fire(2'b11, TRIG_SRC_THRESH, 1'b1, len);
    drain();
    fire(2'b11, TRIG_SRC_SW, 1'b1, len);
    drain();
    finish_test();

    start_test("FIFO full overflow and reset");
    pop_en = 1'b0;
    set_cfg(4, 3, 4, 5);
    repeat (5) fire(2'b01, TRIG_SRC_SW, 1'b1, len);
    repeat (4) @(negedge clk);
    check_bit(o_overflow[0], 1'b1, "o_overflow[0] with FIFO full");
    check_bit(o_overflow[1], 1'b0, "o_overflow[1] with FIFO full");
    // frozen channel ignores this one
    fire(2'b01, TRIG_SRC_SW, 1'b0, len);
    pop_en = 1'b1;
    drain();
    check_bit(o_overflow[0], 1'b1, "o_overflow[0] after draining");
    // leave one header in the FIFO for reset to clear
    pop_en = 1'b0;
    fire(2'b10, TRIG_SRC_SW, 1'b1, len);
    check_bit(o_hdr_valid, 1'b1, "o_hdr_valid before reset");
    do_reset();
    pop_en = 1'b1;
    check_bit(o_overflow[0], 1'b0, "o_overflow[0] after reset");
    check_bit(o_hdr_valid, 1'b0, "o_hdr_valid after reset");
    fire(2'b01, TRIG_SRC_SW, 1'b1, len);
    drain();
    check_bit(o_overflow[0], 1'b0, "o_overflow[0] after normal event");
    finish_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors", n_tests, n_failed, checks, errors);
    if (errors == 0 && n_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
wvb_trig_pkg.sv
wvb_hdr_pkg.sv
wvb_wr_ctrl.sv
wvb_sample_buf.sv
wvb_hdr_arbiter.sv
wvb_hdr_fifo.sv
wvb_top.sv
tb_wvb.sv

/* wvb_cfg.svh */
/*
 * Width, channel count and FIFO depth definitions for the waveform buffer.
 * Include wherever a port or a type needs these sizes.
 */
`ifndef WVB_CFG_SVH
`define WVB_CFG_SVH

// sample ring address and sample word
`define WVB_ADR_W 8
`define WVB_DATA_W 12
`define WVB_LTC_W 32

`define WVB_N_CH 2
`define WVB_HDR_DEPTH 4

// length configuration field widths
`define WVB_PRE_W 5
`define WVB_POST_W 8
`define WVB_TEST_W 8
`define WVB_CONST_W 8

`endif

/* wvb_hdr_arbiter.sv */
/*
 * Round-robin header arbiter. Each channel owns one pending slot; one slot
 * is pushed into the shared FIFO per cycle, tagged with its channel index.
 */
`timescale 1ns/1ns
`include "wvb_cfg.svh"

module wvb_hdr_arbiter (
  input  logic                    clk,
  input  logic                    i_rst,
  input  wvb_hdr_pkg::wvb_hdr_t   i_hdr [`WVB_N_CH],
  input  logic [`WVB_N_CH-1:0]    i_hdr_wren,
  input  logic                    i_fifo_full,
  output logic [`WVB_N_CH-1:0]    o_overflow,
  output logic                    o_push,
  output wvb_hdr_pkg::hdr_entry_t o_entry
);
  import wvb_hdr_pkg::*;

  wvb_hdr_t             pend_hdr [`WVB_N_CH];
  logic [`WVB_N_CH-1:0] pend_vld;
  logic [`WVB_N_CH-1:0] slot_free;
  logic [`WVB_N_CH-1:0] slot_load;
  ch_idx_t              last_gnt;
  ch_idx_t              gnt_ch;
  logic                 gnt_vld;

  // search starts one past the last grant
  always_comb begin
    gnt_vld = 1'b0;
    gnt_ch  = last_gnt;
    for (int i = 1; i <= `WVB_N_CH; i++) begin
      if (!gnt_vld && pend_vld[(int'(last_gnt) + i) % `WVB_N_CH]) begin
        gnt_vld = 1'b1;
        gnt_ch  = ch_idx_t'((int'(last_gnt) + i) % `WVB_N_CH);
      end
    end
  end

  assign o_push        = gnt_vld && !i_fifo_full;
  assign o_entry.ch    = gnt_ch;
  assign o_entry.hdr   = pend_hdr[gnt_ch];
  // a held slot with nowhere to go is an overflow for that channel
  assign o_overflow    = pend_vld & {`WVB_N_CH{i_fifo_full}};

  // a slot emptied by this push can take a new header on the same edge
  always_comb begin
    for (int k = 0; k < `WVB_N_CH; k++) begin
      slot_free[k] = o_push && (int'(gnt_ch) == k);
      slot_load[k] = i_hdr_wren[k] && (!pend_vld[k] || slot_free[k]);
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      pend_vld <= '0;
      last_gnt <= ch_idx_t'(`WVB_N_CH - 1);
    end else begin
      if (o_push) begin
        last_gnt <= gnt_ch;
      end
      for (int k = 0; k < `WVB_N_CH; k++) begin
        if (slot_load[k]) begin
          pend_vld[k] <= 1'b1;
        end else if (slot_free[k]) begin
          pend_vld[k] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < `WVB_N_CH; k++) begin
      if (slot_load[k]) begin
        pend_hdr[k] <= i_hdr[k];
      end
    end
  end

endmodule

/* wvb_hdr_fifo.sv */
/*
 * Show-ahead header FIFO between the arbiter and the host. The head entry
 * is visible on o_entry whenever o_valid is high; i_pop removes it.
 */
`timescale 1ns/1ns
`include "wvb_cfg.svh"

module wvb_hdr_fifo (
  input  logic                    clk,
  input  logic                    i_rst,
  input  logic                    i_push,
  input  wvb_hdr_pkg::hdr_entry_t i_entry,
  input  logic                    i_pop,
  output logic                    o_full,
  output logic                    o_valid,
  output wvb_hdr_pkg::hdr_entry_t o_entry
);
  import wvb_hdr_pkg::*;

  localparam int DEPTH = `WVB_HDR_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  hdr_entry_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign o_full  = (count == CNT_W'(DEPTH));
  assign o_valid = (count != '0);
  assign o_entry = mem[rd_ptr];

  // pop on empty is ignored, so is push on full
  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && o_valid;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_entry;
    end
  end

endmodule

/* wvb_hdr_pkg.sv */
/*
 * Header-side types: the per-event header written at the end of a waveform
 * and the channel-tagged entry held in the shared header FIFO.
 */
`include "wvb_cfg.svh"

package wvb_hdr_pkg;

  typedef logic [$clog2(`WVB_N_CH)-1:0] ch_idx_t;

  typedef struct packed {
    logic [`WVB_LTC_W-1:0]   evt_ltc;
    logic [`WVB_ADR_W-1:0]   start_addr;
    // address of the final sample, inclusive
    logic [`WVB_ADR_W-1:0]   stop_addr;
    wvb_trig_pkg::trig_src_t trig_src;
    logic                    cnst_run;
    logic [`WVB_PRE_W-1:0]   pre_conf;
    logic                    sync_rdy;
  } wvb_hdr_t;

  // entry as pushed by the arbiter
  typedef struct packed {
    ch_idx_t  ch;
    wvb_hdr_t hdr;
  } hdr_entry_t;

endpackage

/* wvb_sample_buf.sv */
/*
 * Sample ring for one channel. Written by the write controller,
 * read by the host with data returned one cycle after the address.
 */
`timescale 1ns/1ns
`include "wvb_cfg.svh"

module wvb_sample_buf (
  input  logic                  clk,
  input  logic                  i_wren,
  input  logic [`WVB_ADR_W-1:0] i_wr_addr,
  input  logic [`WVB_DATA_W-1:0] i_wr_data,
  input  logic [`WVB_ADR_W-1:0] i_rd_addr,
  output logic [`WVB_DATA_W-1:0] o_rd_data
);

  logic [`WVB_DATA_W-1:0] mem [2**`WVB_ADR_W];

  always_ff @(posedge clk) begin
    if (i_wren) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // registered read port
  always_ff @(posedge clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

/* wvb_top.sv */
/*
 * Two-channel waveform buffer front end. Each channel has a write controller
 * and a sample ring; headers from both share one FIFO through the arbiter.
 */
`timescale 1ns/1ns
`include "wvb_cfg.svh"

module wvb_top (
  input  logic                    clk,
  input  logic                    i_rst,
  input  logic [`WVB_LTC_W-1:0]   i_ltc,
  input  wvb_trig_pkg::len_cfg_t  i_len_cfg,
  input  logic                    i_trig_mode,
  input  logic                    i_cnst_run,
  input  logic [`WVB_N_CH-1:0]    i_arm,
  input  logic [`WVB_N_CH-1:0]    i_trig,
  input  wvb_trig_pkg::trig_src_t i_trig_src [`WVB_N_CH],
  input  logic                    i_sync_rdy,
  input  logic [`WVB_DATA_W-1:0]  i_sample [`WVB_N_CH],
  input  wvb_hdr_pkg::ch_idx_t    i_rd_ch,
  input  logic [`WVB_ADR_W-1:0]   i_rd_addr,
  input  logic                    i_hdr_rd,
  output logic [`WVB_N_CH-1:0]    o_armed,
  output logic [`WVB_N_CH-1:0]    o_overflow,
  output logic                    o_hdr_valid,
  output wvb_hdr_pkg::hdr_entry_t o_hdr,
  output logic [`WVB_DATA_W-1:0]  o_rd_data
);
  import wvb_hdr_pkg::*;

  wvb_hdr_t              ch_hdr [`WVB_N_CH];
  logic [`WVB_N_CH-1:0]  ch_hdr_wren;
  logic [`WVB_N_CH-1:0]  ch_wren;
  logic [`WVB_ADR_W-1:0] ch_wr_addr [`WVB_N_CH];
  logic [`WVB_DATA_W-1:0] ch_rd_data [`WVB_N_CH];
  logic [`WVB_N_CH-1:0]  arb_overflow;
  logic                  fifo_push;
  logic                  fifo_full;
  hdr_entry_t            fifo_entry;
  // channel select lines up with the registered read data
  ch_idx_t               rd_ch_q;

  for (genvar g = 0; g < `WVB_N_CH; g++) begin : g_ch
    wvb_wr_ctrl u_wr_ctrl (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_ltc         (i_ltc),
      .i_len_cfg     (i_len_cfg),
      .i_trig_mode   (i_trig_mode),
      .i_cnst_run    (i_cnst_run),
      .i_arm         (i_arm[g]),
      .i_trig        (i_trig[g]),
      .i_trig_src    (i_trig_src[g]),
      .i_overflow    (arb_overflow[g]),
      .i_sync_rdy    (i_sync_rdy),
      .o_overflow    (o_overflow[g]),
      .o_armed       (o_armed[g]),
      .o_wvb_wr_addr (ch_wr_addr[g]),
      .o_wvb_wren    (ch_wren[g]),
      .o_hdr         (ch_hdr[g]),
      .o_hdr_wren    (ch_hdr_wren[g])
    );

    wvb_sample_buf u_sample_buf (
      .clk       (clk),
      .i_wren    (ch_wren[g]),
      .i_wr_addr (ch_wr_addr[g]),
      .i_wr_data (i_sample[g]),
      .i_rd_addr (i_rd_addr),
      .o_rd_data (ch_rd_data[g])
    );
  end

  wvb_hdr_arbiter u_hdr_arbiter (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_hdr       (ch_hdr),
    .i_hdr_wren  (ch_hdr_wren),
    .i_fifo_full (fifo_full),
    .o_overflow  (arb_overflow),
    .o_push      (fifo_push),
    .o_entry     (fifo_entry)
  );

  wvb_hdr_fifo u_hdr_fifo (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_push  (fifo_push),
    .i_entry (fifo_entry),
    .i_pop   (i_hdr_rd),
    .o_full  (fifo_full),
    .o_valid (o_hdr_valid),
    .o_entry (o_hdr)
  );

  always_ff @(posedge clk) begin
    rd_ch_q <= i_rd_ch;
  end

  assign o_rd_data = ch_rd_data[rd_ch_q];

endmodule

/* wvb_trig_pkg.sv */
/*
 * Trigger-side types: where a trigger came from and how long the
 * resulting waveform is configured to be.
 */
`include "wvb_cfg.svh"

package wvb_trig_pkg;

  typedef enum logic [1:0] {
    TRIG_SRC_THRESH = 2'd0,
    TRIG_SRC_SW     = 2'd1,
    TRIG_SRC_EXT    = 2'd2,
    TRIG_SRC_UNUSED = 2'd3
  } trig_src_t;

  // raw lengths as set by the host, clamped later by the write controller
  typedef struct packed {
    logic [`WVB_PRE_W-1:0]   pre_len;
    logic [`WVB_POST_W-1:0]  post_len;
    logic [`WVB_TEST_W-1:0]  test_len;
    logic [`WVB_CONST_W-1:0] const_len;
  } len_cfg_t;

endpackage

/* wvb_wr_ctrl.sv */
/*
 * Per-channel waveform write controller. A trigger starts an event, the FSM
 * then writes a run of consecutive samples into the ring and raises
 * o_hdr_wren together with the last write. One instance per channel.
 */
`timescale 1ns/1ns
`include "wvb_cfg.svh"

module wvb_wr_ctrl (
  input  logic                    clk,
  input  logic                    i_rst,
  input  logic [`WVB_LTC_W-1:0]   i_ltc,
  input  wvb_trig_pkg::len_cfg_t  i_len_cfg,
  input  logic                    i_trig_mode,
  input  logic                    i_cnst_run,
  input  logic                    i_arm,
  input  logic                    i_trig,
  input  wvb_trig_pkg::trig_src_t i_trig_src,
  input  logic                    i_overflow,
  input  logic                    i_sync_rdy,
  output logic                    o_overflow,
  output logic                    o_armed,
  output logic [`WVB_ADR_W-1:0]   o_wvb_wr_addr,
  output logic                    o_wvb_wren,
  output wvb_hdr_pkg::wvb_hdr_t   o_hdr,
  output logic                    o_hdr_wren
);
  import wvb_trig_pkg::*;

  // lengths below these are raised to them
  localparam logic [`WVB_PRE_W-1:0]   PRE_MIN   = 3;
  localparam logic [`WVB_POST_W-1:0]  POST_MIN  = 2;
  localparam logic [`WVB_TEST_W-1:0]  TEST_MIN  = 3;
  localparam logic [`WVB_CONST_W-1:0] CONST_MIN = 3;

  typedef enum logic [2:0] {
    S_IDLE,
    S_PRE,
    S_SOT,
    S_POST,
    S_TEST,
    S_CONST
  } state_t;

  state_t fsm;
  logic [`WVB_ADR_W-1:0] cnt;
  // length of the sample-over-threshold window, grows on retrigger
  logic [`WVB_ADR_W-1:0] sot_cnt;

  logic [`WVB_PRE_W-1:0]   pre_conf;
  logic [`WVB_POST_W-1:0]  post_conf;
  logic [`WVB_TEST_W-1:0]  test_conf;
  logic [`WVB_CONST_W-1:0] const_conf;
  logic [`WVB_POST_W-1:0]  post_cnt_max;
  logic [`WVB_TEST_W-1:0]  test_cnt_max;
  logic [`WVB_CONST_W-1:0] const_cnt_max;

  logic [`WVB_LTC_W-1:0] evt_ltc_q;
  logic [`WVB_ADR_W-1:0] start_addr_q;
  trig_src_t             trig_src_q;
  logic                  cnst_run_q;
  logic                  sync_rdy_q;

  logic final_cnt_check;
  logic final_write;
  logic write_cond;

  // clamp in idle, count limits follow one cycle behind
  always_ff @(posedge clk) begin
    if (fsm == S_IDLE) begin
      pre_conf   <= (i_len_cfg.pre_len >= PRE_MIN) ? i_len_cfg.pre_len : PRE_MIN;
      post_conf  <= (i_len_cfg.post_len >= POST_MIN) ? i_len_cfg.post_len : POST_MIN;
      test_conf  <= (i_len_cfg.test_len >= TEST_MIN) ? i_len_cfg.test_len : TEST_MIN;
      const_conf <= (i_len_cfg.const_len >= CONST_MIN) ? i_len_cfg.const_len : CONST_MIN;

      post_cnt_max  <= post_conf - 1'b1;
      test_cnt_max  <= test_conf - 1'b1;
      const_cnt_max <= const_conf - 1'b1;
    end
  end

  // header fields captured while idle, so the trigger cycle values stick
  always_ff @(posedge clk) begin
    if (fsm == S_IDLE) begin
      evt_ltc_q    <= i_ltc;
      start_addr_q <= o_wvb_wr_addr;
      trig_src_q   <= i_trig_src;
      cnst_run_q   <= i_cnst_run;
      sync_rdy_q   <= i_sync_rdy;
    end
  end

  // stop address tracks the write address and is right on the final write
  always_comb begin
    o_hdr.evt_ltc    = evt_ltc_q;
    o_hdr.start_addr = start_addr_q;
    o_hdr.stop_addr  = o_wvb_wr_addr;
    o_hdr.trig_src   = trig_src_q;
    o_hdr.cnst_run   = cnst_run_q;
    o_hdr.pre_conf   = pre_conf;
    o_hdr.sync_rdy   = sync_rdy_q;
  end

  // sticky until reset, stops all writes
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_overflow <= 1'b0;
    end else if (i_overflow) begin
      o_overflow <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_armed <= 1'b0;
    end else if (i_arm) begin
      o_armed <= 1'b1;
    end else if (o_hdr_wren) begin
      o_armed <= 1'b0;
    end
  end

  // compare against max - 1 so the flag is set in the cycle cnt reaches max
  always_ff @(posedge clk) begin
    if (i_rst) begin
      final_cnt_check <= 1'b0;
    end else begin
      case (fsm)
        S_POST:  final_cnt_check <= (cnt == post_cnt_max - 1'b1);
        S_TEST:  final_cnt_check <= (cnt == test_cnt_max - 1'b1);
        S_CONST: final_cnt_check <= (cnt == const_cnt_max - 1'b1);
        default: final_cnt_check <= 1'b0;
      endcase
    end
  end

  always_comb begin
    case (fsm)
      S_POST:  final_write = !i_trig && final_cnt_check;
      S_TEST:  final_write = final_cnt_check;
      S_CONST: final_write = final_cnt_check;
      default: final_write = 1'b0;
    endcase
  end

  assign write_cond = (i_trig && !i_overflow) || (fsm != S_IDLE);
  assign o_wvb_wren = !o_overflow && write_cond && (!i_trig_mode || o_armed);
  assign o_hdr_wren = o_wvb_wren && final_write;

  always_ff @(posedge clk) begin
    if (i_rst || o_overflow) begin
      fsm           <= S_IDLE;
      cnt           <= '0;
      sot_cnt       <= '0;
      o_wvb_wr_addr <= '0;
    end else begin
      // hold the address when the write is about to overflow
      if (o_wvb_wren && !i_overflow) begin
        o_wvb_wr_addr <= o_wvb_wr_addr + 1'b1;
      end

      case (fsm)
        S_IDLE: begin
          cnt <= '0;
          if (o_wvb_wren) begin
            cnt <= 1;
            if (i_trig_src == TRIG_SRC_SW || i_trig_src == TRIG_SRC_EXT) begin
              fsm <= S_TEST;
            end else if (i_cnst_run) begin
              fsm <= S_CONST;
            end else begin
              sot_cnt <= 1;
              fsm     <= S_PRE;
            end
          end
        end

        // pre_conf samples after the trigger sample
        S_PRE: begin
          cnt <= cnt + 1'b1;
          if (i_trig) begin
            sot_cnt <= cnt + 1'b1;
          end
          if (cnt == `WVB_ADR_W'(pre_conf)) begin
            cnt <= '0;
            fsm <= S_SOT;
          end
        end

        S_SOT: begin
          cnt <= cnt + 1'b1;
          if (i_trig) begin
            cnt     <= '0;
            sot_cnt <= `WVB_ADR_W'(pre_conf);
          end else if (cnt == sot_cnt - 1'b1) begin
            cnt <= '0;
            fsm <= S_POST;
          end
        end

        // a retrigger here reopens the window and restarts the post count
        S_POST: begin
          cnt <= cnt + 1'b1;
          if (i_trig) begin
            cnt     <= '0;
            sot_cnt <= `WVB_ADR_W'(pre_conf);
            fsm     <= S_SOT;
          end else if (cnt == `WVB_ADR_W'(post_cnt_max)) begin
            cnt <= '0;
            fsm <= S_IDLE;
          end
        end

        S_TEST: begin
          cnt <= cnt + 1'b1;
          if (cnt == `WVB_ADR_W'(test_cnt_max)) begin
            cnt <= '0;
            fsm <= S_IDLE;
          end
        end

        S_CONST: begin
          cnt <= cnt + 1'b1;
          if (cnt == `WVB_ADR_W'(const_cnt_max)) begin
            cnt <= '0;
            fsm <= S_IDLE;
          end
        end

        default: begin
          fsm <= S_IDLE;
        end
      endcase
    end
  end

endmodule
